// File: common/loader_consts.svh
//==========================================================================
// Widths, counts and clock enable positions for the cartridge loader
// Included by the package and by any module that needs a constant
//==========================================================================
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// Address and bus widths
`define ROM_AW       22
`define DL_AW        25
`define DL_IW        7                 // Download index width

// Backup RAM and cartridge image
`define BK_SECTORS   64
`define HDR_BYTES    512
`define CODE_INDEX   {`DL_IW{1'b1}}    // Cheat download index

// Clock enable divider
`define CE_PERIOD    30
`define CE_VDP_STEP  5                 // VDP enable every 5 cycles
`define CE_PIX_STEP  10
`define CE_CPU_POS_A 9
`define CE_CPU_POS_B 24

`endif

// File: common/loader_pkg.sv
//==========================================================================
// Shared types of the cartridge loader
// Imported by every loader module that uses a bus, record or state
//==========================================================================
`include "loader_consts.svh"

package loader_pkg;

	typedef logic [`ROM_AW-1:0]             rom_addr_t;
	typedef logic [`DL_AW-1:0]              dl_addr_t;
	typedef logic [7:0]                     byte_t;
	typedef logic [$clog2(`BK_SECTORS)-1:0] lba_t;

	// One host download beat
	typedef struct packed {
		logic             wr;      // One cycle per byte
		dl_addr_t         addr;
		byte_t            data;
		logic [`DL_IW-1:0] index;
		logic             active;  // High for the whole download
	} dl_bus_t;

	typedef struct packed {
		rom_addr_t addr;
		byte_t     data;
	} rom_wr_t;

	// Multi-byte fields are little endian in the download
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_rec_t;

	typedef struct packed {
		lba_t lba;
		logic write;   // High for save, low for load
	} bk_cmd_t;

	typedef enum logic [1:0] {BK_IDLE, BK_REQ, BK_RELEASE} bk_state_e;

endpackage

// File: design/media_ctrl.sv
`timescale 1ns/1ns
//==========================================================================
// Download classifier, backup RAM sector sequencer and console reset
// Sits between the host port and the loader datapaths
//==========================================================================
`include "loader_consts.svh"

module media_ctrl import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  dl_bus_t dl,
	input  logic    bk_load,
	input  logic    bk_save,
	input  logic    img_mounted,
	input  logic    img_readonly,
	input  logic    img_size_nz,
	input  logic    nv_wr,
	input  logic    bk_ack,
	output logic    cart_dl,
	output logic    code_dl,
	output logic    cart_wr,
	output logic    dl_start,
	output logic    dl_end,
	output logic    bk_req,
	output bk_cmd_t bk_cmd,
	output logic    bk_pending,
	output logic    sys_rst_n
);

	logic      cart_q;
	logic      cart_rise;
	logic      bk_ena;
	logic      load_q;
	logic      save_q;
	logic      start_load;
	logic      bk_start;
	logic      bk_loading;
	logic      run;
	bk_state_e bk_state;

	//======================================================================
	// Download classification
	//======================================================================
	assign code_dl   = dl.active && (dl.index == `CODE_INDEX);
	assign cart_dl   = dl.active && (dl.index != `CODE_INDEX);
	assign cart_wr   = dl.wr && cart_dl;
	assign cart_rise = cart_dl && !cart_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cart_q   <= 1'b0;
			dl_start <= 1'b0;
			dl_end   <= 1'b0;
		end else begin
			cart_q   <= cart_dl;
			dl_start <= cart_rise;
			dl_end   <= cart_q && !cart_dl;   // Falling edge, one cycle late
		end
	end

	// Save file is mounted while the cartridge streams in
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_rise)
				bk_ena <= 1'b0;
			if (cart_dl && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
		end
	end

	//======================================================================
	// Backup sector sequencer
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			load_q <= 1'b0;
			save_q <= 1'b0;
		end else begin
			load_q <= bk_load && bk_ena;
			save_q <= bk_save && bk_ena;
		end
	end

	// Manual load or automatic load after a cartridge
	assign start_load = (bk_load && bk_ena && !load_q) || (dl_end && img_size_nz && bk_ena);
	assign bk_start   = (bk_state == BK_IDLE) &&
	                    (start_load || (bk_save && bk_ena && !save_q));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bk_state   <= BK_IDLE;
			bk_cmd     <= '0;
			bk_loading <= 1'b0;
		end else begin
			case (bk_state)
				BK_IDLE: if (bk_start) begin
					bk_cmd.lba   <= '0;
					bk_cmd.write <= !start_load;   // Load wins a tie
					bk_loading   <= start_load;
					bk_state     <= BK_REQ;
				end
				BK_REQ: if (bk_ack)
					bk_state <= BK_RELEASE;
				BK_RELEASE: if (!bk_ack) begin
					if (bk_cmd.lba == lba_t'(`BK_SECTORS - 1)) begin
						bk_loading <= 1'b0;
						bk_state   <= BK_IDLE;
					end else begin
						bk_cmd.lba <= bk_cmd.lba + 1'b1;
						bk_state   <= BK_REQ;
					end
				end
				default: bk_state <= BK_IDLE;
			endcase
		end
	end

	assign bk_req = (bk_state == BK_REQ);

	// Unsaved backup writes
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			bk_pending <= 1'b0;
		else if (bk_start)
			bk_pending <= 1'b0;
		else if (nv_wr && bk_ena)
			bk_pending <= 1'b1;
	end

	// Console held off until one clean cycle after reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	assign sys_rst_n = run && !cart_dl && !bk_loading;

	a_cmd_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(bk_req && $past(bk_req)) |-> $stable(bk_cmd));

endmodule

// File: design/rom_writer.sv
`timescale 1ns/1ns
//==========================================================================
// Cartridge byte writer with four-phase req/ack toward ROM memory
// Holds the host off with dl_wait until each write completes
//==========================================================================

module rom_writer import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    cart_wr,
	input  byte_t   data,
	input  logic    dl_start,
	input  logic    mem_ack,
	output logic    mem_req,
	output rom_wr_t mem_wr,
	output logic    dl_wait
);

	rom_addr_t wr_addr;
	logic      release_wait;   // Request dropped, waiting for ack low

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mem_req      <= 1'b0;
			dl_wait      <= 1'b0;
			release_wait <= 1'b0;
			wr_addr      <= '0;
		end else begin
			if (cart_wr && !dl_wait) begin
				dl_wait <= 1'b1;
			end else if (dl_wait && !mem_req && !release_wait) begin
				mem_req <= 1'b1;               // Payload is already steady
			end else if (mem_req && mem_ack) begin
				mem_req      <= 1'b0;
				release_wait <= 1'b1;
			end else if (release_wait && !mem_ack) begin
				release_wait <= 1'b0;
				dl_wait      <= 1'b0;
				wr_addr      <= wr_addr + 1'b1;
			end
			if (dl_start)
				wr_addr <= '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr && !dl_wait) begin
			mem_wr.addr <= dl_start ? '0 : wr_addr;
			mem_wr.data <= data;
		end
	end

	a_req_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(mem_req) |-> $past(mem_ack));

endmodule

// File: design/rom_map.sv
`timescale 1ns/1ns
//==========================================================================
// Cartridge size masks and console ROM read address translation
// Masks are learned from the download addresses of each cartridge
//==========================================================================
`include "loader_consts.svh"

module rom_map import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      cart_wr,
	input  dl_addr_t  addr,
	input  logic      dl_end,
	input  rom_addr_t rom_rd_addr,
	output rom_addr_t mem_rd_addr
);

	rom_addr_t mask;
	rom_addr_t mask_hdr;   // Mask of the image behind a header
	dl_addr_t  size;
	logic      size_b9;
	logic      hdr;

	assign size = addr + 1'b1;   // Bytes loaded so far

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mask     <= '0;
			mask_hdr <= '0;
			size_b9  <= 1'b0;
			hdr      <= 1'b0;
		end else begin
			if (cart_wr) begin
				mask    <= (addr == '0) ? '0 : (mask | rom_addr_t'(addr));
				size_b9 <= size[9];
				if (addr == dl_addr_t'(`HDR_BYTES))
					mask_hdr <= '0;
				else if (addr > dl_addr_t'(`HDR_BYTES))
					mask_hdr <= mask_hdr | rom_addr_t'(addr - `HDR_BYTES);
			end
			if (dl_end)
				hdr <= size_b9;   // Odd half-KB size means a header
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr)
			mem_rd_addr <= rom_addr_t'(rom_rd_addr + `HDR_BYTES) & mask_hdr;
		else
			mem_rd_addr <= rom_rd_addr & mask;
	end

endmodule

// File: design/cheat_loader.sv
`timescale 1ns/1ns
//==========================================================================
// Cheat record assembler
// Packs 16 download bytes into one record and strobes it out
//==========================================================================

module cheat_loader import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  dl_bus_t    dl,
	input  logic       code_dl,
	output cheat_rec_t cheat,
	output logic       cheat_valid,
	output logic       cheat_clear
);

	logic       code_wr;
	logic [4:0] bsel;   // Bit offset of the byte within its field

	assign code_wr = dl.wr && code_dl;
	assign bsel    = {dl.addr[1:0], 3'b000};

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:2])
				2'd0: cheat.flags[bsel +: 8]   <= dl.data;
				2'd1: cheat.address[bsel +: 8] <= dl.data;
				2'd2: cheat.compare[bsel +: 8] <= dl.data;
				default: cheat.replace[bsel +: 8] <= dl.data;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl.addr[3:0] == 4'hF);   // Last byte
			// First byte of any download drops old cheats
			cheat_clear <= dl.wr && dl.active && (dl.addr == '0);
		end
	end

endmodule

// File: design/ce_gen.sv
`timescale 1ns/1ns
//==========================================================================
// Clock enable divider for the CPU, VDP and pixel pipelines
// One modulo counter, enables registered from its count
//==========================================================================
`include "loader_consts.svh"

module ce_gen (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix
);

	localparam int CW = $clog2(`CE_PERIOD);

	logic [CW-1:0] cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
		end else begin
			cnt <= (cnt == CW'(`CE_PERIOD - 1)) ? '0 : cnt + 1'b1;

			ce_vdp <= (cnt % `CE_VDP_STEP) == (`CE_VDP_STEP - 1);
			ce_pix <= (cnt % `CE_PIX_STEP) == (`CE_PIX_STEP - 1);
			// CPU phase sits off the pixel grid on the second half
			ce_cpu <= (cnt == CW'(`CE_CPU_POS_A)) || (cnt == CW'(`CE_CPU_POS_B));
		end
	end

	a_ce_align: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ce_pix || ce_cpu) |-> ce_vdp);

endmodule

// File: design/cart_loader_top.sv
`timescale 1ns/1ns
//==========================================================================
// Media loading side of the console core
// Connects download control, ROM writer, address map, cheats and enables
//==========================================================================

module cart_loader_top import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  dl_bus_t    dl,
	input  logic       bk_load,
	input  logic       bk_save,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  logic       img_size_nz,
	input  logic       nv_wr,
	input  logic       mem_ack,
	input  logic       bk_ack,
	input  rom_addr_t  rom_rd_addr,
	output logic       dl_wait,
	output logic       mem_req,
	output rom_wr_t    mem_wr,
	output rom_addr_t  mem_rd_addr,
	output cheat_rec_t cheat,
	output logic       cheat_valid,
	output logic       cheat_clear,
	output logic       bk_req,
	output bk_cmd_t    bk_cmd,
	output logic       bk_pending,
	output logic       sys_rst_n,
	output logic       ce_cpu,
	output logic       ce_vdp,
	output logic       ce_pix
);

	logic code_dl;
	logic cart_wr;
	logic dl_start;
	logic dl_end;

	media_ctrl u_ctrl (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl          (dl),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size_nz (img_size_nz),
		.nv_wr       (nv_wr),
		.bk_ack      (bk_ack),
		.cart_dl     (),
		.code_dl     (code_dl),
		.cart_wr     (cart_wr),
		.dl_start    (dl_start),
		.dl_end      (dl_end),
		.bk_req      (bk_req),
		.bk_cmd      (bk_cmd),
		.bk_pending  (bk_pending),
		.sys_rst_n   (sys_rst_n)
	);

	rom_writer u_rom_writer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cart_wr (cart_wr),
		.data    (dl.data),
		.dl_start(dl_start),
		.mem_ack (mem_ack),
		.mem_req (mem_req),
		.mem_wr  (mem_wr),
		.dl_wait (dl_wait)
	);

	rom_map u_rom_map (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cart_wr    (cart_wr),
		.addr       (dl.addr),
		.dl_end     (dl_end),
		.rom_rd_addr(rom_rd_addr),
		.mem_rd_addr(mem_rd_addr)
	);

	cheat_loader u_cheat_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl),
		.code_dl    (code_dl),
		.cheat      (cheat),
		.cheat_valid(cheat_valid),
		.cheat_clear(cheat_clear)
	);

	ce_gen u_ce_gen (
		.clk_sys(clk_sys),
		.rst_n  (rst_n),
		.ce_cpu (ce_cpu),
		.ce_vdp (ce_vdp),
		.ce_pix (ce_pix)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ns
//==========================================================================
// Testbench clock and reset source, 40 ns period
//==========================================================================

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2 rst_n = 1'b1;   // Released at the drive point
	end

endmodule

// File: dv/cart_loader_tb.sv
`timescale 1ns/1ns
//==========================================================================
// Testbench for the cartridge loader with memory and storage models
// Run from the project root through the file list
//==========================================================================
`include "loader_consts.svh"

module cart_loader_tb import loader_pkg::*;;

	localparam int TEST_CYCLES = 3670 * 10 + 3 * `BK_SECTORS * 10 + 500;
	localparam int LIMIT       = 2 * TEST_CYCLES;

	logic clk_sys, rst_n;
	dl_bus_t dl;
	logic bk_load, bk_save, img_mounted, img_readonly, img_size_nz, nv_wr;
	logic mem_ack, bk_ack;
	rom_addr_t rom_rd_addr, mem_rd_addr;
	logic dl_wait, mem_req, cheat_valid, cheat_clear, bk_req, bk_pending, sys_rst_n;
	logic ce_cpu, ce_vdp, ce_pix;
	rom_wr_t mem_wr;
	cheat_rec_t cheat;
	bk_cmd_t bk_cmd;

	logic [15:0]  lfsr = 16'd34380;
	byte_t        wr_q[$];        // Bytes sent and not yet written
	int           wr_idx, bk_cnt, valid_cnt, clr_cnt, cycles, ce_k, ce_pos;
	logic         exp_write, bk_forbid;
	logic [127:0] exp_cheat;

	tb_clock u_clock (.clk_sys(clk_sys), .rst_n(rst_n));

	cart_loader_top u_dut (.*);

	//======================================================================
	// Helpers
	//======================================================================
	task automatic check_eq(input string name, input logic [127:0] exp, input logic [127:0] act);
		assert (exp === act) else begin
			$display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("test failed");
		$fatal(1);
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic byte_t rand_byte();
		byte_t b;
		for (int n = 0; n < 8; n++) begin
			b[n] = lfsr[0];
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return b;
	endfunction

	task automatic next_drive();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic run_download(input logic [`DL_IW-1:0] idx, input int nbytes);
		byte_t b;
		logic  is_cart;
		is_cart  = (idx != `CODE_INDEX);
		wr_idx   = 0;
		dl.index = idx;
		dl.active = 1'b1;
		repeat (2) next_drive();
		for (int i = 0; i < nbytes; i++) begin
			b       = rand_byte();
			dl.addr = dl_addr_t'(i);
			dl.data = b;
			dl.wr   = 1'b1;
			if (is_cart)
				wr_q.push_back(b);
			else
				exp_cheat[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = b;
			next_drive();
			dl.wr = 1'b0;
			if (is_cart) begin
				check_eq("dl_wait", 128'(1'b1), 128'(dl_wait));
				while (dl_wait)
					next_drive();
			end else begin
				next_drive();
			end
		end
		next_drive();
		dl.active = 1'b0;
		repeat (3) next_drive();
		if (wr_q.size() != 0)
			report_error("cartridge bytes never reached memory");
	endtask

	task automatic check_map(input int offs);
		rom_addr_t a;
		for (int n = 0; n < 8; n++) begin
			a = rom_addr_t'({rand_byte(), rand_byte(), rand_byte()});
			rom_rd_addr = a;
			@(posedge clk_sys);
			#1 check_eq("mem_rd_addr", 128'(rom_addr_t'((a + offs) & 1023)), 128'(mem_rd_addr));
			#1;
		end
	endtask

	//======================================================================
	// Memory and storage models
	//======================================================================
	always begin
		@(posedge clk_sys);
		#1;
		if (mem_req && !mem_ack) begin
			if (wr_q.size() == 0)
				report_error("memory write without a cartridge byte");
			check_eq("mem_wr.addr", 128'(wr_idx), 128'(mem_wr.addr));
			check_eq("mem_wr.data", 128'(wr_q.pop_front()), 128'(mem_wr.data));
			wr_idx++;
			repeat (1 + wr_idx % 3) @(posedge clk_sys);
			#2 mem_ack = 1'b1;
			do begin
				@(posedge clk_sys);
				#1;
			end while (mem_req);
			#1 mem_ack = 1'b0;
		end
	end

	always begin
		@(posedge clk_sys);
		#1;
		if (bk_req && !bk_ack) begin
			if (bk_forbid)
				report_error("backup request while the save image is read-only");
			check_eq("bk_cmd.lba", 128'(bk_cnt % `BK_SECTORS), 128'(bk_cmd.lba));
			check_eq("bk_cmd.write", 128'(exp_write), 128'(bk_cmd.write));
			if (!exp_write)
				check_eq("sys_rst_n", 128'(1'b0), 128'(sys_rst_n));
			repeat (2 + bk_cnt % 2) @(posedge clk_sys);
			#2 bk_ack = 1'b1;
			do begin
				@(posedge clk_sys);
				#1;
			end while (bk_req);
			bk_cnt++;
			#1 bk_ack = 1'b0;
		end
	end

	//======================================================================
	// Monitors and timeout
	//======================================================================
	always begin
		@(posedge clk_sys);
		if (rst_n) begin
			#1;
			ce_pos = ce_k % `CE_PERIOD;
			check_eq("ce_vdp", 128'(ce_pos inside {4, 9, 14, 19, 24, 29}), 128'(ce_vdp));
			check_eq("ce_pix", 128'(ce_pos inside {9, 19, 29}), 128'(ce_pix));
			check_eq("ce_cpu", 128'(ce_pos inside {9, 24}), 128'(ce_cpu));
			ce_k++;
			if (cheat_valid) begin
				valid_cnt++;
				check_eq("cheat", exp_cheat, 128'(cheat));
			end
			if (cheat_clear)
				clr_cnt++;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles", cycles);
			$display("test failed");
			$fatal(1);
		end
	end

	a_wait_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_req |-> dl_wait) else report_error("mem_req while dl_wait is low");

	a_cart_reset: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(dl.active && dl.index != `CODE_INDEX) |-> !sys_rst_n)
		else report_error("console out of reset during a cartridge download");

	//======================================================================
	// Test sequence
	//======================================================================
	initial begin
		dl = '0;
		{bk_load, bk_save, img_mounted, img_readonly, img_size_nz, nv_wr} = '0;
		{mem_ack, bk_ack, exp_write, bk_forbid} = '0;
		rom_rd_addr = '0;
		exp_cheat   = '0;
		{wr_idx, bk_cnt, valid_cnt, clr_cnt, ce_k} = '0;

		@(posedge rst_n);
		next_drive();
		check_eq("idle outputs", 128'(0),
			128'({mem_req, bk_req, dl_wait, cheat_valid, cheat_clear, bk_pending}));

		run_download(7'd0, 1030);            // Plain cartridge writes
		run_download(7'd0, 1024);
		check_map(0);
		run_download(7'd0, 1536);            // Image behind a header
		check_map(`HDR_BYTES);

		clr_cnt   = 0;
		valid_cnt = 0;
		run_download(`CODE_INDEX, 16);
		check_eq("cheat_valid count", 128'(1), 128'(valid_cnt));
		check_eq("cheat_clear count", 128'(1), 128'(clr_cnt));

		// Automatic load after a cartridge with a writable save
		img_mounted = 1'b1;
		img_size_nz = 1'b1;
		bk_cnt      = 0;
		run_download(7'd1, 64);
		while (bk_cnt < `BK_SECTORS)
			next_drive();
		repeat (2) next_drive();
		check_eq("sys_rst_n", 128'(1'b1), 128'(sys_rst_n));

		nv_wr = 1'b1;
		next_drive();
		nv_wr = 1'b0;
		next_drive();
		check_eq("bk_pending", 128'(1'b1), 128'(bk_pending));

		exp_write = 1'b1;
		bk_cnt    = 0;
		bk_save   = 1'b1;
		while (!bk_req)
			next_drive();
		check_eq("bk_pending", 128'(1'b0), 128'(bk_pending));
		while (bk_cnt < `BK_SECTORS)
			next_drive();
		bk_save = 1'b0;
		next_drive();                        // Sequencer back to idle

		exp_write = 1'b0;
		bk_cnt    = 0;
		bk_load   = 1'b1;
		next_drive();
		check_eq("sys_rst_n", 128'(1'b0), 128'(sys_rst_n));
		while (bk_cnt < `BK_SECTORS)
			next_drive();
		bk_load = 1'b0;
		repeat (2) next_drive();
		check_eq("sys_rst_n", 128'(1'b1), 128'(sys_rst_n));

		// Read-only save blocks every transfer
		img_readonly = 1'b1;
		bk_forbid    = 1'b1;
		run_download(7'd2, 16);
		bk_load = 1'b1;
		repeat (20) next_drive();
		bk_load = 1'b0;
		bk_save = 1'b1;
		repeat (20) next_drive();
		bk_save = 1'b0;
		repeat (50) next_drive();

		if (wr_q.size() != 0 || bk_cnt != `BK_SECTORS) begin
			report_error("memory or backup traffic left over at the end");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: compile.f
+incdir+common
common/loader_pkg.sv
design/media_ctrl.sv
design/rom_writer.sv
design/rom_map.sv
design/cheat_loader.sv
design/ce_gen.sv
design/cart_loader_top.sv
dv/tb_clock.sv
dv/cart_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the loader testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cart_loader_tb \
	-o sim_cart_loader || { echo "build failed"; exit 1; }

./obj_dir/sim_cart_loader > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
